// ==== sources.f ====
verilog/eth_frame_pkg.sv
verilog/eth_bd_pkg.sv
verilog/eth_bd_if.sv
verilog/eth_bd_table.sv
verilog/eth_tx_engine.sv
verilog/eth_rx_engine.sv
verilog/eth_dma_top.sv
verif/eth_dma_properties.sv
verif/eth_dma_tb.sv

// ==== Bender.yml ====
package:
  name: eth_dma

sources:
  # Packages and interface first, then the modules that use them
  - verilog/eth_frame_pkg.sv
  - verilog/eth_bd_pkg.sv
  - verilog/eth_bd_if.sv
  - verilog/eth_bd_table.sv
  - verilog/eth_tx_engine.sv
  - verilog/eth_rx_engine.sv
  - verilog/eth_dma_top.sv
  - target: test
    files:
      - verif/eth_dma_properties.sv
      - verif/eth_dma_tb.sv

// ==== verif/eth_dma_tb.sv ====
`timescale 1ns/1ps

module eth_dma_tb;
   import eth_frame_pkg::*;
   import eth_bd_pkg::*;

   localparam int unsigned N_ROWS   = 8;
   localparam int unsigned MAX_LEN  = 40;
   localparam int unsigned GATE_CYC = 30;
   localparam bd_num_t     RX_BASE  = 7'd64;

   typedef struct packed {
      logic    rx;
      bd_num_t idx;
      nbytes_t len;
      logic    irq;
      logic    wrap;
      logic    crc_en;
      logic    crc_err;
   } row_t;

   // Direction, index, length, irq, wrap, crc_en, crc_err
   // Indices follow each ring as the wrap flags move it
   localparam row_t ROWS [N_ROWS] = '{
      '{1'b0, 7'd0,  11'd16, 1'b1, 1'b0, 1'b1, 1'b0},
      '{1'b0, 7'd1,  11'd5,  1'b0, 1'b1, 1'b0, 1'b0},
      '{1'b1, 7'd64, 11'd20, 1'b1, 1'b0, 1'b0, 1'b0},
      '{1'b0, 7'd0,  11'd33, 1'b1, 1'b0, 1'b0, 1'b0},
      '{1'b1, 7'd65, 11'd9,  1'b0, 1'b1, 1'b0, 1'b1},
      '{1'b0, 7'd1,  11'd7,  1'b0, 1'b0, 1'b1, 1'b0},
      '{1'b0, 7'd2,  11'd40, 1'b1, 1'b0, 1'b1, 1'b0},
      '{1'b1, 7'd64, 11'd3,  1'b1, 1'b0, 1'b0, 1'b0}
   };

   logic        clk_i = 1'b0;
   logic        arst_i;
   logic        tx_en_i;
   logic        rx_en_i;
   bd_num_t     tx_bd_num_i;
   logic        bd_en_i;
   logic        bd_wen_i;
   bd_addr_t    bd_addr_i;
   bd_word_t    bd_wdata_i;
   bd_word_t    bd_rdata_o;
   logic        eth_data_wr_wen_o;
   buf_addr_t   eth_data_wr_addr_o;
   frame_byte_t eth_data_wr_wdata_o;
   logic        tx_ready_i;
   logic        crc_en_o;
   nbytes_t     tx_nbytes_o;
   logic        send_o;
   buf_addr_t   eth_data_rd_addr_o;
   frame_byte_t eth_data_rd_rdata_i = '0;
   logic        rx_data_rcvd_i;
   logic        crc_err_i;
   nbytes_t     rx_nbytes_i;
   logic        rcv_ack_o;
   logic        tx_irq_o;
   logic        rx_irq_o;
   logic        tx_frame_word_wen_i;
   frame_byte_t tx_frame_word_wdata_i;
   logic        tx_frame_word_ready_o;
   logic        rx_frame_word_ren_i;
   frame_byte_t rx_frame_word_rdata_o;
   logic        rx_frame_word_rvalid_o;
   logic        rx_frame_word_ready_o;

   frame_byte_t txbuf [2**BUFFER_W];
   frame_byte_t rxbuf [2**BUFFER_W];
   frame_byte_t frame_data [MAX_LEN];
   buf_addr_t   rd_addr_s;
   int unsigned tx_irq_cnt = 0;
   int unsigned rx_irq_cnt = 0;

   eth_dma_top u_dut (.*);

   always #5 clk_i = ~clk_i;

   // Transmit frame buffer records every write
   always @(posedge clk_i) begin
      if (eth_data_wr_wen_o) begin
         txbuf[eth_data_wr_addr_o] = eth_data_wr_wdata_o;
      end
   end

   // Receive frame buffer answers one cycle after the address
   always @(posedge clk_i) begin
      rd_addr_s = eth_data_rd_addr_o;
      #1;
      eth_data_rd_rdata_i = rxbuf[rd_addr_s];
   end

   always @(posedge clk_i) begin
      if (tx_irq_o) begin
         tx_irq_cnt++;
      end
      if (rx_irq_o) begin
         rx_irq_cnt++;
      end
   end

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("TEST FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_byte(input frame_byte_t got, input frame_byte_t exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch at %0t: %s is %02h, expected %02h",
                                 $time, what, got, exp));
      end
   endtask

   task automatic check_word(input bd_word_u got, input bd_word_u exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch at %0t: %s is %08h, expected %08h",
                                 $time, what, got, exp));
      end
   endtask

   task automatic check_nbytes(input nbytes_t got, input nbytes_t exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch at %0t: %s is %0d, expected %0d",
                                 $time, what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("mismatch at %0t: %s is %b, expected %b",
                                 $time, what, got, exp));
      end
   endtask

   task automatic next_cycle();
      @(posedge clk_i);
      #1;
   endtask

   task automatic write_bd(input bd_addr_t addr, input bd_word_t data);
      bd_en_i    = 1'b1;
      bd_wen_i   = 1'b1;
      bd_addr_i  = addr;
      bd_wdata_i = data;
      next_cycle();
      bd_en_i  = 1'b0;
      bd_wen_i = 1'b0;
   endtask

   task automatic read_bd(input bd_addr_t addr, output bd_word_u data);
      bd_en_i   = 1'b1;
      bd_wen_i  = 1'b0;
      bd_addr_i = addr;
      next_cycle();
      bd_en_i = 1'b0;
      data    = bd_rdata_o;
   endtask

   function automatic bd_word_t status_word(input row_t r, input logic ready);
      bd_word_t w;
      w     = '0;
      w[15] = ready;
      w[14] = r.irq;
      w[13] = r.wrap;
      if (!r.rx) begin
         w[31:16] = 16'(r.len);
         w[11]    = r.crc_en;
      end
      return w;
   endfunction

   // Status expected once the engine hands the descriptor back
   function automatic bd_word_t done_word(input row_t r);
      bd_word_t w;
      w = status_word(r, 1'b0);
      if (r.rx) begin
         w[31:16] = 16'(r.len);
         w[1]     = r.crc_err;
      end
      return w;
   endfunction

   task automatic hold_disabled(input bd_addr_t a, input bd_word_u exp);
      bd_word_u rd;
      repeat (GATE_CYC) begin
         next_cycle();
         check_flag(tx_frame_word_ready_o, 1'b0, "tx_frame_word_ready_o while disabled");
         check_flag(rx_frame_word_ready_o, 1'b0, "rx_frame_word_ready_o while disabled");
         check_flag(send_o, 1'b0, "send_o while disabled");
         check_flag(rcv_ack_o, 1'b0, "rcv_ack_o while disabled");
      end
      read_bd(a, rd);
      check_word(rd, exp, "status word while disabled");
   endtask

   task automatic send_frame(input row_t r);
      int unsigned sent;
      sent = 0;
      while (sent < r.len) begin
         tx_frame_word_wen_i   = tx_frame_word_ready_o;
         tx_frame_word_wdata_i = frame_data[sent];
         if (tx_frame_word_ready_o) begin
            sent++;
         end
         next_cycle();
      end
      tx_frame_word_wen_i = 1'b0;
      while (!send_o) begin
         next_cycle();
      end
      for (int i = 0; i < r.len; i++) begin
         check_byte(txbuf[PRE_FRAME_LEN + i], frame_data[i], "transmit buffer byte");
      end
      check_nbytes(tx_nbytes_o, nbytes_t'(PRE_FRAME_LEN + r.len), "tx_nbytes_o");
      check_flag(crc_en_o, r.crc_en, "crc_en_o");
      // Transmitter takes the frame
      tx_ready_i = 1'b0;
      next_cycle();
      check_flag(send_o, 1'b0, "send_o after tx_ready_i fell");
   endtask

   task automatic receive_frame(input row_t r);
      int unsigned got;
      got = 0;
      while (got < r.len) begin
         rx_frame_word_ren_i = rx_frame_word_ready_o;
         next_cycle();
         if (rx_frame_word_ren_i) begin
            check_flag(rx_frame_word_rvalid_o, 1'b1, "rx_frame_word_rvalid_o after read");
            check_flag(rx_frame_word_ready_o, 1'b0, "rx_frame_word_ready_o after read");
            check_byte(rx_frame_word_rdata_o, frame_data[got], "received byte");
            got++;
         end else begin
            check_flag(rx_frame_word_rvalid_o, 1'b0, "rx_frame_word_rvalid_o without read");
         end
      end
      rx_frame_word_ren_i = 1'b0;
      while (!rcv_ack_o) begin
         next_cycle();
      end
      rx_data_rcvd_i = 1'b0;
      next_cycle();
      check_flag(rcv_ack_o, 1'b0, "rcv_ack_o after rx_data_rcvd_i fell");
   endtask

   task automatic run_row(input row_t r);
      bd_addr_t    a;
      bd_word_u    rd;
      int unsigned tx_irq_base;
      int unsigned rx_irq_base;
      a           = {r.idx, 1'b0};
      tx_irq_base = tx_irq_cnt;
      rx_irq_base = rx_irq_cnt;
      for (int i = 0; i < MAX_LEN; i++) begin
         frame_data[i] = frame_byte_t'($urandom);
      end
      // Descriptor goes in while its engine is disabled
      if (r.rx) begin
         rx_en_i = 1'b0;
      end else begin
         tx_en_i = 1'b0;
      end
      write_bd(a + 1'b1, bd_word_t'($urandom));
      write_bd(a, status_word(r, 1'b1));
      // Frame side ready, so only the enable holds the engine back
      if (r.rx) begin
         for (int i = 0; i < r.len; i++) begin
            rxbuf[i] = frame_data[i];
         end
         rx_nbytes_i    = r.len;
         crc_err_i      = r.crc_err;
         rx_data_rcvd_i = 1'b1;
      end else begin
         tx_ready_i = 1'b1;
      end
      hold_disabled(a, status_word(r, 1'b1));
      tx_en_i = 1'b1;
      rx_en_i = 1'b1;
      if (r.rx) begin
         receive_frame(r);
      end else begin
         send_frame(r);
      end
      // Served once the ready bit reads back cleared
      read_bd(a, rd);
      while (rd.tx.ready) begin
         read_bd(a, rd);
      end
      check_word(rd, done_word(r), "written-back status word");
      check_flag(tx_irq_cnt != tx_irq_base, r.irq && !r.rx, "tx_irq_o pulse");
      check_flag(rx_irq_cnt != rx_irq_base, r.irq && r.rx, "rx_irq_o pulse");
   endtask

   // Watchdog sized from the row count and the longest frame
   initial begin
      repeat (N_ROWS * (4 * MAX_LEN + 300)) @(posedge clk_i);
      stop_on_error("timeout, the run did not finish in the allowed number of cycles");
   end

   initial begin
      void'($urandom(32'h89b7dfdc));
      arst_i                = 1'b1;
      tx_en_i               = 1'b1;
      rx_en_i               = 1'b1;
      tx_bd_num_i           = RX_BASE;
      bd_en_i               = 1'b0;
      bd_wen_i              = 1'b0;
      bd_addr_i             = '0;
      bd_wdata_i            = '0;
      tx_ready_i            = 1'b0;
      rx_data_rcvd_i        = 1'b0;
      crc_err_i             = 1'b0;
      rx_nbytes_i           = '0;
      tx_frame_word_wen_i   = 1'b0;
      tx_frame_word_wdata_i = '0;
      rx_frame_word_ren_i   = 1'b0;
      for (int i = 0; i < 2**BUFFER_W; i++) begin
         rxbuf[i] = frame_byte_t'(i ^ (i >> 3));
      end
      repeat (10) @(posedge clk_i);
      #1;
      check_flag(send_o, 1'b0, "send_o in reset");
      check_flag(rcv_ack_o, 1'b0, "rcv_ack_o in reset");
      check_flag(tx_irq_o, 1'b0, "tx_irq_o in reset");
      check_flag(rx_irq_o, 1'b0, "rx_irq_o in reset");
      check_flag(tx_frame_word_ready_o, 1'b0, "tx_frame_word_ready_o in reset");
      check_flag(rx_frame_word_ready_o, 1'b0, "rx_frame_word_ready_o in reset");
      check_flag(rx_frame_word_rvalid_o, 1'b0, "rx_frame_word_rvalid_o in reset");
      arst_i = 1'b0;
      // Start from an empty table
      for (int i = 0; i < 2 * BD_NUM; i++) begin
         write_bd(bd_addr_t'(i), '0);
      end
      for (int i = 0; i < PREAMBLE_LEN; i++) begin
         check_byte(txbuf[i], PREAMBLE_BYTE, "preamble byte");
      end
      check_byte(txbuf[PREAMBLE_LEN], SFD_BYTE, "start-of-frame delimiter");
      for (int n = 0; n < N_ROWS; n++) begin
         run_row(ROWS[n]);
      end
      if (u_dut.u_props.fail_count != 0) begin
         stop_on_error($sformatf("%0d assertion failures were reported",
                                 u_dut.u_props.fail_count));
      end else begin
         $display("TEST PASS");
         $finish;
      end
   end

endmodule

// ==== verif/eth_dma_properties.sv ====
`timescale 1ns/1ps

module eth_dma_properties (
   input logic clk_i,
   input logic arst_i,
   input logic send_o,
   input logic rcv_ack_o,
   input logic tx_irq_o,
   input logic rx_irq_o,
   input logic tx_ready_i,
   input logic rx_frame_word_ren_i,
   input logic rx_frame_word_ready_o,
   input logic rx_frame_word_rvalid_o
);

   int unsigned fail_count = 0;

   // Completion levels come up low out of reset
   a_quiet_after_reset: assert property (@(posedge clk_i)
      arst_i |=> !send_o && !rcv_ack_o)
   else begin
      $error("send_o or rcv_ack_o high right after reset");
      fail_count++;
   end

   a_tx_irq_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
      tx_irq_o |=> !tx_irq_o)
   else begin
      $error("tx_irq_o high for more than one cycle");
      fail_count++;
   end

   a_rx_irq_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
      rx_irq_o |=> !rx_irq_o)
   else begin
      $error("rx_irq_o high for more than one cycle");
      fail_count++;
   end

   // Read data valid exactly one cycle after an accepted read
   a_rvalid_timing: assert property (@(posedge clk_i) disable iff (arst_i)
      rx_frame_word_rvalid_o == $past(rx_frame_word_ren_i && rx_frame_word_ready_o))
   else begin
      $error("rx_frame_word_rvalid_o not one cycle after an accepted read");
      fail_count++;
   end

   a_send_held: assert property (@(posedge clk_i) disable iff (arst_i)
      send_o && tx_ready_i |=> send_o)
   else begin
      $error("send_o dropped while tx_ready_i was high");
      fail_count++;
   end

endmodule

bind eth_dma_top eth_dma_properties u_props (.*);

// ==== verilog/eth_dma_top.sv ====
`timescale 1ns/1ps

module eth_dma_top (
   input  logic                       clk_i,
   input  logic                       arst_i,
   input  logic                       tx_en_i,
   input  logic                       rx_en_i,
   input  eth_bd_pkg::bd_num_t        tx_bd_num_i,
   input  logic                       bd_en_i,
   input  logic                       bd_wen_i,
   input  eth_bd_pkg::bd_addr_t       bd_addr_i,
   input  eth_bd_pkg::bd_word_t       bd_wdata_i,
   output eth_bd_pkg::bd_word_t       bd_rdata_o,
   output logic                       eth_data_wr_wen_o,
   output eth_frame_pkg::buf_addr_t   eth_data_wr_addr_o,
   output eth_frame_pkg::frame_byte_t eth_data_wr_wdata_o,
   input  logic                       tx_ready_i,
   output logic                       crc_en_o,
   output eth_frame_pkg::nbytes_t     tx_nbytes_o,
   output logic                       send_o,
   output eth_frame_pkg::buf_addr_t   eth_data_rd_addr_o,
   input  eth_frame_pkg::frame_byte_t eth_data_rd_rdata_i,
   input  logic                       rx_data_rcvd_i,
   input  logic                       crc_err_i,
   input  eth_frame_pkg::nbytes_t     rx_nbytes_i,
   output logic                       rcv_ack_o,
   output logic                       tx_irq_o,
   output logic                       rx_irq_o,
   input  logic                       tx_frame_word_wen_i,
   input  eth_frame_pkg::frame_byte_t tx_frame_word_wdata_i,
   output logic                       tx_frame_word_ready_o,
   input  logic                       rx_frame_word_ren_i,
   output eth_frame_pkg::frame_byte_t rx_frame_word_rdata_o,
   output logic                       rx_frame_word_rvalid_o,
   output logic                       rx_frame_word_ready_o
);

   // One table access path per engine
   eth_bd_if tx_bd_if ();
   eth_bd_if rx_bd_if ();

   eth_bd_table u_bd_table (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .bd_en_i    (bd_en_i),
      .bd_wen_i   (bd_wen_i),
      .bd_addr_i  (bd_addr_i),
      .bd_wdata_i (bd_wdata_i),
      .bd_rdata_o (bd_rdata_o),
      .tx_bd      (tx_bd_if),
      .rx_bd      (rx_bd_if)
   );

   eth_tx_engine u_tx_engine (
      .clk_i                 (clk_i),
      .arst_i                (arst_i),
      .tx_en_i               (tx_en_i),
      .bd                    (tx_bd_if),
      .tx_ready_i            (tx_ready_i),
      .eth_data_wr_wen_o     (eth_data_wr_wen_o),
      .eth_data_wr_addr_o    (eth_data_wr_addr_o),
      .eth_data_wr_wdata_o   (eth_data_wr_wdata_o),
      .crc_en_o              (crc_en_o),
      .tx_nbytes_o           (tx_nbytes_o),
      .send_o                (send_o),
      .tx_frame_word_wen_i   (tx_frame_word_wen_i),
      .tx_frame_word_wdata_i (tx_frame_word_wdata_i),
      .tx_frame_word_ready_o (tx_frame_word_ready_o),
      .tx_irq_o              (tx_irq_o)
   );

   eth_rx_engine u_rx_engine (
      .clk_i                  (clk_i),
      .arst_i                 (arst_i),
      .rx_en_i                (rx_en_i),
      .tx_bd_num_i            (tx_bd_num_i),
      .bd                     (rx_bd_if),
      .rx_data_rcvd_i         (rx_data_rcvd_i),
      .crc_err_i              (crc_err_i),
      .rx_nbytes_i            (rx_nbytes_i),
      .rcv_ack_o              (rcv_ack_o),
      .eth_data_rd_addr_o     (eth_data_rd_addr_o),
      .eth_data_rd_rdata_i    (eth_data_rd_rdata_i),
      .rx_frame_word_ren_i    (rx_frame_word_ren_i),
      .rx_frame_word_rdata_o  (rx_frame_word_rdata_o),
      .rx_frame_word_rvalid_o (rx_frame_word_rvalid_o),
      .rx_frame_word_ready_o  (rx_frame_word_ready_o),
      .rx_irq_o               (rx_irq_o)
   );

endmodule

// ==== verilog/eth_rx_engine.sv ====
`timescale 1ns/1ps

module eth_rx_engine (
   input  logic                       clk_i,
   input  logic                       arst_i,
   input  logic                       rx_en_i,
   input  eth_bd_pkg::bd_num_t        tx_bd_num_i,
   eth_bd_if.engine                   bd,
   input  logic                       rx_data_rcvd_i,
   input  logic                       crc_err_i,
   input  eth_frame_pkg::nbytes_t     rx_nbytes_i,
   output logic                       rcv_ack_o,
   output eth_frame_pkg::buf_addr_t   eth_data_rd_addr_o,
   input  eth_frame_pkg::frame_byte_t eth_data_rd_rdata_i,
   input  logic                       rx_frame_word_ren_i,
   output eth_frame_pkg::frame_byte_t rx_frame_word_rdata_o,
   output logic                       rx_frame_word_rvalid_o,
   output logic                       rx_frame_word_ready_o,
   output logic                       rx_irq_o
);
   import eth_frame_pkg::*;
   import eth_bd_pkg::*;

   enum logic [2:0] {
      S_REQ,
      S_CHK,
      S_WAIT,
      S_BYTES,
      S_ACK,
      S_WB
   } state_q;

   bd_num_t  num_q;
   bd_word_u desc_q;
   bd_word_u rd_word;
   nbytes_t  cnt_q;
   nbytes_t  cnt_inc;
   logic     gap_q;
   logic     ren_ok;
   logic     frame_done;

   assign rd_word    = bd.rdata;
   assign cnt_inc    = cnt_q + 1'b1;
   assign ren_ok     = rx_frame_word_ready_o & rx_frame_word_ren_i;
   assign frame_done = ren_ok ? (cnt_inc == rx_nbytes_i) : (cnt_q == rx_nbytes_i);

   // Buffer read data lags the address by one cycle
   assign eth_data_rd_addr_o = buf_addr_t'(cnt_q);

   // One idle cycle after each byte while the next address settles
   assign rx_frame_word_ready_o = (state_q == S_BYTES) && !gap_q && (cnt_q != rx_nbytes_i);

   always_comb begin
      bd.req   = (state_q == S_REQ) || (state_q == S_WB);
      bd.addr  = {num_q, 1'b0};
      bd.wen   = (state_q == S_WB);
      bd.wdata = desc_q;
      rx_irq_o = (state_q == S_WB) && bd.grant && desc_q.rx.irq;
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q                <= S_REQ;
         num_q                  <= tx_bd_num_i;
         cnt_q                  <= '0;
         gap_q                  <= 1'b0;
         rcv_ack_o              <= 1'b0;
         rx_frame_word_rvalid_o <= 1'b0;
      end else begin
         gap_q                  <= ren_ok;
         rx_frame_word_rvalid_o <= ren_ok;
         case (state_q)
            S_REQ: begin
               if (bd.grant) begin
                  state_q <= S_CHK;
               end
            end
            S_CHK: begin
               cnt_q <= '0;
               if (rd_word.rx.ready && rx_en_i) begin
                  state_q <= S_WAIT;
               end else begin
                  state_q <= S_REQ;
               end
            end
            S_WAIT: begin
               if (rx_data_rcvd_i) begin
                  state_q <= S_BYTES;
               end
            end
            S_BYTES: begin
               if (ren_ok) begin
                  cnt_q <= cnt_inc;
               end
               if (frame_done) begin
                  rcv_ack_o <= 1'b1;
                  state_q   <= S_ACK;
               end
            end
            S_ACK: begin
               if (!rx_data_rcvd_i) begin
                  rcv_ack_o <= 1'b0;
                  state_q   <= S_WB;
               end
            end
            S_WB: begin
               // RX ring restarts at the first RX descriptor
               if (bd.grant) begin
                  if (desc_q.rx.wrap || (&num_q)) begin
                     num_q <= tx_bd_num_i;
                  end else begin
                     num_q <= num_q + 1'b1;
                  end
                  state_q <= S_REQ;
               end
            end
            default: state_q <= S_REQ;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (ren_ok) begin
         rx_frame_word_rdata_o <= eth_data_rd_rdata_i;
      end
   end

   // Status for write-back: length, CRC result, ready cleared
   always_ff @(posedge clk_i) begin
      if (state_q == S_CHK) begin
         desc_q <= rd_word;
      end else if (state_q == S_BYTES && frame_done) begin
         desc_q.rx.length  <= {5'd0, rx_nbytes_i};
         desc_q.rx.crc_err <= crc_err_i;
         desc_q.rx.ready   <= 1'b0;
      end
   end

endmodule

// ==== verilog/eth_tx_engine.sv ====
`timescale 1ns/1ps

module eth_tx_engine (
   input  logic                       clk_i,
   input  logic                       arst_i,
   input  logic                       tx_en_i,
   eth_bd_if.engine                   bd,
   input  logic                       tx_ready_i,
   output logic                       eth_data_wr_wen_o,
   output eth_frame_pkg::buf_addr_t   eth_data_wr_addr_o,
   output eth_frame_pkg::frame_byte_t eth_data_wr_wdata_o,
   output logic                       crc_en_o,
   output eth_frame_pkg::nbytes_t     tx_nbytes_o,
   output logic                       send_o,
   input  logic                       tx_frame_word_wen_i,
   input  eth_frame_pkg::frame_byte_t tx_frame_word_wdata_i,
   output logic                       tx_frame_word_ready_o,
   output logic                       tx_irq_o
);
   import eth_frame_pkg::*;
   import eth_bd_pkg::*;

   enum logic [2:0] {
      S_PRE,
      S_REQ,
      S_CHK,
      S_WAIT,
      S_BYTES,
      S_SEND,
      S_WB
   } state_q;

   bd_num_t  num_q;
   bd_word_u desc_q;
   bd_word_u rd_word;
   nbytes_t  cnt_q;
   nbytes_t  cnt_inc;
   nbytes_t  len;
   logic     wen_ok;
   logic     frame_done;

   assign rd_word    = bd.rdata;
   assign len        = nbytes_t'(desc_q.tx.length);
   assign cnt_inc    = cnt_q + 1'b1;
   assign wen_ok     = tx_frame_word_ready_o & tx_frame_word_wen_i;
   assign frame_done = wen_ok ? (cnt_inc == len) : (cnt_q == len);

   // Host may push bytes until the descriptor length is reached
   assign tx_frame_word_ready_o = (state_q == S_BYTES) && (cnt_q != len);

   always_comb begin
      bd.req              = 1'b0;
      bd.addr             = {num_q, 1'b0};
      bd.wen              = 1'b0;
      bd.wdata            = desc_q;
      eth_data_wr_wen_o   = 1'b0;
      eth_data_wr_addr_o  = buf_addr_t'(PRE_FRAME_LEN) + buf_addr_t'(cnt_q);
      eth_data_wr_wdata_o = tx_frame_word_wdata_i;
      tx_irq_o            = 1'b0;
      case (state_q)
         S_PRE: begin
            eth_data_wr_wen_o  = 1'b1;
            eth_data_wr_addr_o = buf_addr_t'(cnt_q);
            if (cnt_q == PREAMBLE_LEN) begin
               eth_data_wr_wdata_o = SFD_BYTE;
            end else begin
               eth_data_wr_wdata_o = PREAMBLE_BYTE;
            end
         end
         S_REQ: begin
            bd.req = 1'b1;
         end
         S_BYTES: begin
            eth_data_wr_wen_o = wen_ok;
         end
         S_WB: begin
            bd.req   = 1'b1;
            bd.wen   = 1'b1;
            // Interrupt marks the granted write-back
            tx_irq_o = bd.grant & desc_q.tx.irq;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q     <= S_PRE;
         num_q       <= '0;
         cnt_q       <= '0;
         send_o      <= 1'b0;
         crc_en_o    <= 1'b0;
         tx_nbytes_o <= '0;
      end else begin
         case (state_q)
            S_PRE: begin
               cnt_q <= cnt_inc;
               if (cnt_q == PREAMBLE_LEN) begin
                  state_q <= S_REQ;
               end
            end
            S_REQ: begin
               if (bd.grant) begin
                  state_q <= S_CHK;
               end
            end
            S_CHK: begin
               cnt_q <= '0;
               // Poll again until the descriptor is ready and TX is enabled
               if (rd_word.tx.ready && tx_en_i) begin
                  state_q <= S_WAIT;
               end else begin
                  state_q <= S_REQ;
               end
            end
            S_WAIT: begin
               if (tx_ready_i) begin
                  state_q <= S_BYTES;
               end
            end
            S_BYTES: begin
               if (wen_ok) begin
                  cnt_q <= cnt_inc;
               end
               if (frame_done) begin
                  crc_en_o    <= desc_q.tx.crc_en;
                  tx_nbytes_o <= nbytes_t'(PRE_FRAME_LEN) + len;
                  send_o      <= 1'b1;
                  state_q     <= S_SEND;
               end
            end
            S_SEND: begin
               // Transmitter took the frame
               if (!tx_ready_i) begin
                  send_o  <= 1'b0;
                  state_q <= S_WB;
               end
            end
            S_WB: begin
               if (bd.grant) begin
                  if (desc_q.tx.wrap || (&num_q)) begin
                     num_q <= '0;
                  end else begin
                     num_q <= num_q + 1'b1;
                  end
                  state_q <= S_REQ;
               end
            end
            default: state_q <= S_REQ;
         endcase
      end
   end

   // Descriptor copy, handed back with ready cleared
   always_ff @(posedge clk_i) begin
      if (state_q == S_CHK) begin
         desc_q <= rd_word;
      end else if (state_q == S_BYTES && frame_done) begin
         desc_q.tx.ready <= 1'b0;
      end
   end

endmodule

// ==== verilog/eth_bd_table.sv ====
`timescale 1ns/1ps

module eth_bd_table (
   input  logic                 clk_i,
   input  logic                 arst_i,
   input  logic                 bd_en_i,
   input  logic                 bd_wen_i,
   input  eth_bd_pkg::bd_addr_t bd_addr_i,
   input  eth_bd_pkg::bd_word_t bd_wdata_i,
   output eth_bd_pkg::bd_word_t bd_rdata_o,
   eth_bd_if.tbl                tx_bd,
   eth_bd_if.tbl                rx_bd
);
   import eth_bd_pkg::*;

   bd_word_t mem [2*BD_NUM];
   logic     tx_prio_q;
   logic     eng_access;
   bd_addr_t eng_addr;
   logic     eng_wen;
   bd_word_t eng_wdata;
   bd_word_t eng_rdata_q;

   // Round-robin grant, one requester per cycle
   always_comb begin
      tx_bd.grant = tx_bd.req & (tx_prio_q | ~rx_bd.req);
      rx_bd.grant = rx_bd.req & (~tx_prio_q | ~tx_bd.req);
   end

   assign eng_access = tx_bd.grant | rx_bd.grant;

   // Mux the granted engine onto the RAM port
   always_comb begin
      if (rx_bd.grant) begin
         eng_addr  = rx_bd.addr;
         eng_wen   = rx_bd.wen;
         eng_wdata = rx_bd.wdata;
      end else begin
         eng_addr  = tx_bd.addr;
         eng_wen   = tx_bd.wen;
         eng_wdata = tx_bd.wdata;
      end
   end

   // Priority flips to the other engine after each grant
   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         tx_prio_q <= 1'b1;
      end else if (tx_bd.grant) begin
         tx_prio_q <= 1'b0;
      end else if (rx_bd.grant) begin
         tx_prio_q <= 1'b1;
      end
   end

   // Host port and engine port share the array
   always_ff @(posedge clk_i) begin
      if (bd_en_i && bd_wen_i) begin
         mem[bd_addr_i] <= bd_wdata_i;
      end
      if (eng_access && eng_wen) begin
         mem[eng_addr] <= eng_wdata;
      end
   end

   always_ff @(posedge clk_i) begin
      if (bd_en_i && !bd_wen_i) begin
         bd_rdata_o <= mem[bd_addr_i];
      end
   end

   // Read word goes back to whichever engine asked
   always_ff @(posedge clk_i) begin
      if (eng_access && !eng_wen) begin
         eng_rdata_q <= mem[eng_addr];
      end
   end

   assign tx_bd.rdata = eng_rdata_q;
   assign rx_bd.rdata = eng_rdata_q;

endmodule

// ==== verilog/eth_bd_if.sv ====
`timescale 1ns/1ps

interface eth_bd_if;
   import eth_bd_pkg::*;

   logic     req;
   bd_addr_t addr;
   logic     wen;
   bd_word_t wdata;
   logic     grant;
   bd_word_t rdata;

   // Requester side holds its request until granted
   modport engine (
      output req, addr, wen, wdata,
      input  grant, rdata
   );

   modport tbl (
      input  req, addr, wen, wdata,
      output grant, rdata
   );

endinterface

// ==== verilog/eth_bd_pkg.sv ====
package eth_bd_pkg;

   // Table geometry, two words per descriptor
   localparam int unsigned BD_NUM    = 128;
   localparam int unsigned BD_ADDR_W = 8;

   typedef logic [$clog2(BD_NUM)-1:0] bd_num_t;
   typedef logic [BD_ADDR_W-1:0]      bd_addr_t;
   typedef logic [31:0]               bd_word_t;

   // Status word, seen by each engine through its own member
   typedef union packed {
      struct packed {
         logic [15:0] length;
         logic        ready;
         logic        irq;
         logic        wrap;
         logic        rsvd_12;
         logic        crc_en;
         logic [10:0] rsvd_10_0;
      } tx;
      struct packed {
         logic [15:0] length;
         logic        ready;
         logic        irq;
         logic        wrap;
         logic [10:0] rsvd_12_2;
         logic        crc_err;
         logic        rsvd_0;
      } rx;
   } bd_word_u;

endpackage

// ==== verilog/eth_frame_pkg.sv ====
package eth_frame_pkg;

   // Frame buffer addressing
   localparam int unsigned BUFFER_W = 11;

   typedef logic [BUFFER_W-1:0] buf_addr_t;
   typedef logic [10:0]         nbytes_t;
   typedef logic [7:0]          frame_byte_t;

   // Preamble and start-of-frame delimiter
   localparam int unsigned PREAMBLE_LEN  = 7;
   localparam frame_byte_t PREAMBLE_BYTE = 8'h55;
   localparam frame_byte_t SFD_BYTE      = 8'hD5;

   // First payload byte sits right after the SFD
   localparam int unsigned PRE_FRAME_LEN = PREAMBLE_LEN + 1;

endpackage
